/* hw/mips_ctrl_pkg.sv */
package mips_ctrl_pkg;

  // Instruction fields
  typedef logic [5:0] opcode_t;
  typedef logic [5:0] funct_t;

  // Datapath selects, numbered as the existing datapath expects
  typedef logic [1:0] alu_src_t;
  typedef logic [2:0] alu_op_t;
  typedef logic [2:0] iord_t;
  typedef logic [2:0] pc_src_t;
  typedef logic [2:0] reg_dst_t;
  typedef logic [3:0] mem_to_reg_t;
  typedef logic [1:0] branch_t;

  localparam alu_src_t SRCA_PC        = 2'b00;
  localparam alu_src_t SRCA_REG_A     = 2'b01;
  localparam alu_src_t SRCB_REG_B     = 2'b00;
  localparam alu_src_t SRCB_FOUR      = 2'b01;
  localparam alu_src_t SRCB_IMM       = 2'b10;
  localparam alu_src_t SRCB_BR_OFFSET = 2'b11;

  localparam alu_op_t ALU_ADD = 3'b001;
  localparam alu_op_t ALU_SUB = 3'b010;
  localparam alu_op_t ALU_AND = 3'b011;
  localparam alu_op_t ALU_SLT = 3'b111;

  localparam iord_t IORD_PC       = 3'b000;
  localparam iord_t IORD_OVF_VEC  = 3'b010;
  localparam iord_t IORD_INEX_VEC = 3'b100;
  localparam iord_t IORD_ALUOUT   = 3'b101;

  localparam pc_src_t PC_SRC_EXC_VEC = 3'b000;
  localparam pc_src_t PC_SRC_ALU     = 3'b001;
  localparam pc_src_t PC_SRC_ALUOUT  = 3'b011;
  localparam pc_src_t PC_SRC_JUMP    = 3'b101;

  localparam reg_dst_t DST_RT = 3'b000;
  localparam reg_dst_t DST_RD = 3'b001;
  localparam reg_dst_t DST_RA = 3'b010;
  localparam reg_dst_t DST_SP = 3'b100;

  localparam mem_to_reg_t WB_ALUOUT  = 4'b0000;
  localparam mem_to_reg_t WB_MEM     = 4'b0001;
  localparam mem_to_reg_t WB_PC      = 4'b0010;
  localparam mem_to_reg_t WB_LT      = 4'b0011;
  localparam mem_to_reg_t WB_SP_INIT = 4'b0110;

  localparam branch_t BR_EQ = 2'b10;
  localparam branch_t BR_NE = 2'b11;

  localparam opcode_t OPCODE_R     = 6'h00;
  localparam opcode_t OPCODE_J     = 6'h02;
  localparam opcode_t OPCODE_JAL   = 6'h03;
  localparam opcode_t OPCODE_BEQ   = 6'h04;
  localparam opcode_t OPCODE_BNE   = 6'h05;
  localparam opcode_t OPCODE_ADDI  = 6'h08;
  localparam opcode_t OPCODE_ADDIU = 6'h09;
  localparam opcode_t OPCODE_LW    = 6'h23;
  localparam opcode_t OPCODE_SW    = 6'h2b;

  localparam funct_t FUNCT_ADD = 6'h20;
  localparam funct_t FUNCT_SUB = 6'h22;
  localparam funct_t FUNCT_AND = 6'h24;
  localparam funct_t FUNCT_SLT = 6'h2a;

  typedef enum logic [3:0] {
    KIND_ADD, KIND_AND, KIND_SUB, KIND_SLT, KIND_ADDI, KIND_ADDIU, KIND_LW,
    KIND_SW, KIND_BEQ, KIND_BNE, KIND_J, KIND_JAL, KIND_ILLEGAL
  } instr_kind_t;

  typedef enum logic [5:0] {
    ST_RESET = 6'h00, ST_FETCH = 6'h01, ST_FETCH_WAIT = 6'h02, ST_DECODE = 6'h04,
    ST_ADD = 6'h05, ST_AND = 6'h06, ST_SLT = 6'h0e, ST_SUB = 6'h12,
    ST_ADDI = 6'h15, ST_BEQ = 6'h17, ST_BNE = 6'h18, ST_LW = 6'h1f,
    ST_SW = 6'h23, ST_J = 6'h24, ST_JAL = 6'h25, ST_ALU_WB = 6'h26,
    ST_IMM_WB = 6'h27, ST_SLT_WB = 6'h2d, ST_LOAD_WAIT = 6'h31, ST_LOAD_WB = 6'h32,
    ST_STORE_WAIT = 6'h33, ST_EXC = 6'h34, ST_EXC_OVF = 6'h35, ST_EXC_INEX = 6'h37,
    ST_EXC_WAIT = 6'h38, ST_EXC_END = 6'h39
  } ctrl_state_t;

endpackage

/* hw/ctrl_word_if.sv */
interface ctrl_word_if;
  import mips_ctrl_pkg::*;

  logic        ir_write;
  logic        reg_write;
  logic        write_mem;
  logic        epc_write;
  logic        pc_write;
  logic        pc_write_cond;
  alu_src_t    alu_srca;
  alu_src_t    alu_srcb;
  alu_op_t     alu_op;
  iord_t       iord;
  pc_src_t     pc_src;
  reg_dst_t    reg_dst;
  mem_to_reg_t mem_to_reg;
  branch_t     branch_type;

  modport gen (
    output ir_write, reg_write, write_mem, epc_write, pc_write, pc_write_cond,
    output alu_srca, alu_srcb, alu_op, iord, pc_src, reg_dst, mem_to_reg, branch_type
  );
  modport user (
    input ir_write, reg_write, write_mem, epc_write, pc_write, pc_write_cond,
    input alu_srca, alu_srcb, alu_op, iord, pc_src, reg_dst, mem_to_reg, branch_type
  );
endinterface

/* hw/instr_decoder.sv */
module instr_decoder (
  input  mips_ctrl_pkg::opcode_t     opcode,
  input  mips_ctrl_pkg::funct_t      funct,
  output mips_ctrl_pkg::instr_kind_t instr_kind
);
  import mips_ctrl_pkg::*;

  always_comb begin
    case (opcode)
      // R type, the funct field picks the ALU operation
      OPCODE_R: begin
        case (funct)
          FUNCT_ADD: begin
            instr_kind = KIND_ADD;
          end
          FUNCT_AND: begin
            instr_kind = KIND_AND;
          end
          FUNCT_SUB: begin
            instr_kind = KIND_SUB;
          end
          FUNCT_SLT: begin
            instr_kind = KIND_SLT;
          end
          default: begin
            instr_kind = KIND_ILLEGAL;
          end
        endcase
      end
      OPCODE_ADDI: begin
        instr_kind = KIND_ADDI;
      end
      OPCODE_ADDIU: begin
        instr_kind = KIND_ADDIU;
      end
      OPCODE_LW: begin
        instr_kind = KIND_LW;
      end
      OPCODE_SW: begin
        instr_kind = KIND_SW;
      end
      OPCODE_BEQ: begin
        instr_kind = KIND_BEQ;
      end
      OPCODE_BNE: begin
        instr_kind = KIND_BNE;
      end
      OPCODE_J: begin
        instr_kind = KIND_J;
      end
      OPCODE_JAL: begin
        instr_kind = KIND_JAL;
      end
      default: begin
        instr_kind = KIND_ILLEGAL;
      end
    endcase
  end

endmodule

/* hw/ctrl_sequencer.sv */
module ctrl_sequencer (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       overflow,
  input  mips_ctrl_pkg::instr_kind_t instr_kind,
  output mips_ctrl_pkg::ctrl_state_t next_state
);
  import mips_ctrl_pkg::*;

  ctrl_state_t state;
  ctrl_state_t seq_state;
  logic        in_exc;
  logic        ovf_entry;
  logic        cause_ovf;

  assign in_exc = state inside {ST_EXC, ST_EXC_OVF, ST_EXC_INEX, ST_EXC_WAIT, ST_EXC_END};
  // Overflow preempts any normal state
  assign ovf_entry = overflow && !in_exc && (state != ST_RESET);

  always_comb begin
    case (state)
      ST_FETCH:      seq_state = ST_FETCH_WAIT;
      ST_FETCH_WAIT: seq_state = ST_DECODE;
      ST_DECODE: begin
        case (instr_kind)
          KIND_ADD:              seq_state = ST_ADD;
          KIND_AND:              seq_state = ST_AND;
          KIND_SUB:              seq_state = ST_SUB;
          KIND_SLT:              seq_state = ST_SLT;
          KIND_ADDI, KIND_ADDIU: seq_state = ST_ADDI;
          KIND_LW:               seq_state = ST_LW;
          KIND_SW:               seq_state = ST_SW;
          KIND_BEQ:              seq_state = ST_BEQ;
          KIND_BNE:              seq_state = ST_BNE;
          KIND_J:                seq_state = ST_J;
          KIND_JAL:              seq_state = ST_JAL;
          default:               seq_state = ST_EXC;
        endcase
      end
      ST_ADD, ST_AND, ST_SUB:  seq_state = ST_ALU_WB;
      ST_SLT:                  seq_state = ST_SLT_WB;
      ST_ADDI:                 seq_state = ST_IMM_WB;
      ST_LW:                   seq_state = ST_LOAD_WAIT;
      ST_LOAD_WAIT:            seq_state = ST_LOAD_WB;
      ST_SW:                   seq_state = ST_STORE_WAIT;
      ST_EXC:                  seq_state = cause_ovf ? ST_EXC_OVF : ST_EXC_INEX;
      ST_EXC_OVF, ST_EXC_INEX: seq_state = ST_EXC_WAIT;
      ST_EXC_WAIT:             seq_state = ST_EXC_END;
      // Last cycle of every instruction
      default:                 seq_state = ST_FETCH;
    endcase
  end

  always_comb begin
    if (reset) begin
      next_state = ST_RESET;
    end else if (ovf_entry) begin
      next_state = ST_EXC;
    end else begin
      next_state = seq_state;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_RESET;
    end else begin
      state <= next_state;
    end
  end

  // Cause of the pending exception, read in ST_EXC
  always_ff @(posedge clock) begin
    if (reset) begin
      cause_ovf <= 1'b0;
    end else if (ovf_entry) begin
      cause_ovf <= 1'b1;
    end else if (state == ST_DECODE && seq_state == ST_EXC) begin
      cause_ovf <= 1'b0;
    end
  end

  a_exc_vector: assert property (@(posedge clock) disable iff (reset)
    state == ST_EXC |=> state inside {ST_EXC_OVF, ST_EXC_INEX});

  a_state_legal: assert property (@(posedge clock)
    state inside {ST_RESET, ST_FETCH, ST_FETCH_WAIT, ST_DECODE, ST_ADD, ST_AND, ST_SUB,
                  ST_SLT, ST_ALU_WB, ST_SLT_WB, ST_ADDI, ST_IMM_WB, ST_LW, ST_LOAD_WAIT,
                  ST_LOAD_WB, ST_SW, ST_STORE_WAIT, ST_BEQ, ST_BNE, ST_J, ST_JAL, ST_EXC,
                  ST_EXC_OVF, ST_EXC_INEX, ST_EXC_WAIT, ST_EXC_END});

endmodule

/* hw/ctrl_word_gen.sv */
module ctrl_word_gen (
  input logic                       clock,
  input mips_ctrl_pkg::ctrl_state_t next_state,
  ctrl_word_if.gen                  word
);
  import mips_ctrl_pkg::*;

  // Word for the state being entered, so it lines up with the state register
  always_ff @(posedge clock) begin
    word.ir_write      <= 1'b0;
    word.reg_write     <= 1'b0;
    word.write_mem     <= 1'b0;
    word.epc_write     <= 1'b0;
    word.pc_write      <= 1'b0;
    word.pc_write_cond <= 1'b0;
    word.alu_srca      <= SRCA_PC;
    word.alu_srcb      <= SRCB_REG_B;
    word.alu_op        <= ALU_ADD;
    word.iord          <= IORD_PC;
    word.pc_src        <= PC_SRC_ALU;
    word.reg_dst       <= DST_RT;
    word.mem_to_reg    <= WB_ALUOUT;
    word.branch_type   <= BR_EQ;
    case (next_state)
      ST_FETCH: begin
        word.ir_write <= 1'b1;
        word.pc_write <= 1'b1;
        word.alu_srcb <= SRCB_FOUR;
      end
      // Branch target computed ahead of the branch itself
      ST_DECODE: begin
        word.alu_srcb <= SRCB_BR_OFFSET;
      end
      ST_ADD, ST_AND, ST_SUB, ST_SLT: begin
        word.alu_srca <= SRCA_REG_A;
        word.alu_op   <= (next_state == ST_AND) ? ALU_AND :
                         (next_state == ST_SUB) ? ALU_SUB :
                         (next_state == ST_SLT) ? ALU_SLT : ALU_ADD;
      end
      ST_ALU_WB, ST_SLT_WB: begin
        word.reg_write  <= 1'b1;
        word.reg_dst    <= DST_RD;
        word.mem_to_reg <= (next_state == ST_SLT_WB) ? WB_LT : WB_ALUOUT;
      end
      ST_ADDI: begin
        word.alu_srca <= SRCA_REG_A;
        word.alu_srcb <= SRCB_IMM;
      end
      ST_IMM_WB: begin
        word.reg_write <= 1'b1;
      end
      ST_LW, ST_SW: begin
        word.alu_srca  <= SRCA_REG_A;
        word.alu_srcb  <= SRCB_IMM;
        word.iord      <= IORD_ALUOUT;
        word.write_mem <= (next_state == ST_SW);
      end
      ST_LOAD_WAIT, ST_STORE_WAIT: begin
        word.iord <= IORD_ALUOUT;
      end
      ST_LOAD_WB: begin
        word.reg_write  <= 1'b1;
        word.mem_to_reg <= WB_MEM;
      end
      ST_BEQ, ST_BNE: begin
        word.pc_write_cond <= 1'b1;
        word.alu_srca      <= SRCA_REG_A;
        word.alu_op        <= ALU_SUB;
        word.pc_src        <= PC_SRC_ALUOUT;
        word.branch_type   <= (next_state == ST_BNE) ? BR_NE : BR_EQ;
      end
      ST_J, ST_JAL: begin
        word.pc_write   <= 1'b1;
        word.pc_src     <= PC_SRC_JUMP;
        word.reg_write  <= (next_state == ST_JAL);
        word.reg_dst    <= DST_RA;
        word.mem_to_reg <= WB_PC;
      end
      // EPC gets PC - 4, the address of the faulting instruction
      ST_EXC: begin
        word.epc_write <= 1'b1;
        word.alu_srcb  <= SRCB_FOUR;
        word.alu_op    <= ALU_SUB;
      end
      ST_EXC_OVF: begin
        word.iord <= IORD_OVF_VEC;
      end
      ST_EXC_INEX: begin
        word.iord <= IORD_INEX_VEC;
      end
      ST_EXC_END: begin
        word.pc_write <= 1'b1;
        word.pc_src   <= PC_SRC_EXC_VEC;
      end
      ST_FETCH_WAIT, ST_EXC_WAIT: begin
      end
      // Stack pointer load
      default: begin
        word.reg_write  <= 1'b1;
        word.reg_dst    <= DST_SP;
        word.mem_to_reg <= WB_SP_INIT;
      end
    endcase
  end

  a_pc_write_excl: assert property (@(posedge clock) !(word.pc_write && word.pc_write_cond));

  a_store_addr: assert property (@(posedge clock) word.write_mem |-> word.iord == IORD_ALUOUT);

endmodule

/* hw/mips_control.sv */
module mips_control (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       overflow,
  input  mips_ctrl_pkg::opcode_t     opcode,
  input  mips_ctrl_pkg::funct_t      funct,
  output logic                       ir_write,
  output logic                       reg_write,
  output logic                       write_mem,
  output logic                       epc_write,
  output logic                       pc_write,
  output logic                       pc_write_cond,
  output mips_ctrl_pkg::alu_src_t    alu_srca,
  output mips_ctrl_pkg::alu_src_t    alu_srcb,
  output mips_ctrl_pkg::alu_op_t     alu_op,
  output mips_ctrl_pkg::iord_t       iord,
  output mips_ctrl_pkg::pc_src_t     pc_src,
  output mips_ctrl_pkg::reg_dst_t    reg_dst,
  output mips_ctrl_pkg::mem_to_reg_t mem_to_reg,
  output mips_ctrl_pkg::branch_t     branch_type
);
  import mips_ctrl_pkg::*;

  instr_kind_t instr_kind;
  ctrl_state_t next_state;

  ctrl_word_if word ();

  instr_decoder u_decoder (
    .opcode     (opcode),
    .funct      (funct),
    .instr_kind (instr_kind)
  );

  ctrl_sequencer u_sequencer (
    .clock      (clock),
    .reset      (reset),
    .overflow   (overflow),
    .instr_kind (instr_kind),
    .next_state (next_state)
  );

  ctrl_word_gen u_word_gen (
    .clock      (clock),
    .next_state (next_state),
    .word       (word.gen)
  );

  assign ir_write      = word.ir_write;
  assign reg_write     = word.reg_write;
  assign write_mem     = word.write_mem;
  assign epc_write     = word.epc_write;
  assign pc_write      = word.pc_write;
  assign pc_write_cond = word.pc_write_cond;
  assign alu_srca      = word.alu_srca;
  assign alu_srcb      = word.alu_srcb;
  assign alu_op        = word.alu_op;
  assign iord          = word.iord;
  assign pc_src        = word.pc_src;
  assign reg_dst       = word.reg_dst;
  assign mem_to_reg    = word.mem_to_reg;
  assign branch_type   = word.branch_type;

endmodule

/* bench/tb_checks.svh */
int value_errors = 0;
int other_errors = 0;

task automatic report_mismatch(input string what, input int actual, input int expected);
  value_errors++;
  $display("Fail at time %0t: %s is %0d, expected %0d", $time, what, actual, expected);
endtask

task automatic check_bit(input logic actual, input logic expected, input string what);
  if (actual !== expected)
    report_mismatch(what, int'(actual), int'(expected));
endtask

task automatic check_alu_src(input alu_src_t actual, input alu_src_t expected,
                             input string what);
  if (actual !== expected)
    report_mismatch(what, int'(actual), int'(expected));
endtask

task automatic check_alu_op(input alu_op_t actual, input alu_op_t expected, input string what);
  if (actual !== expected)
    report_mismatch(what, int'(actual), int'(expected));
endtask

task automatic check_iord(input iord_t actual, input iord_t expected, input string what);
  if (actual !== expected)
    report_mismatch(what, int'(actual), int'(expected));
endtask

task automatic check_pc_src(input pc_src_t actual, input pc_src_t expected, input string what);
  if (actual !== expected)
    report_mismatch(what, int'(actual), int'(expected));
endtask

task automatic check_reg_dst(input reg_dst_t actual, input reg_dst_t expected,
                             input string what);
  if (actual !== expected)
    report_mismatch(what, int'(actual), int'(expected));
endtask

task automatic check_mem_to_reg(input mem_to_reg_t actual, input mem_to_reg_t expected,
                                input string what);
  if (actual !== expected)
    report_mismatch(what, int'(actual), int'(expected));
endtask

task automatic check_branch(input branch_t actual, input branch_t expected, input string what);
  if (actual !== expected)
    report_mismatch(what, int'(actual), int'(expected));
endtask

task automatic check_length(input int actual, input int expected, input string what);
  if (actual != expected)
    report_mismatch(what, actual, expected);
endtask

/* bench/tb_mips_control.sv */
module tb_mips_control;
  import mips_ctrl_pkg::*;

  localparam int CLK_PERIOD = 100;
  // 12 shuffled directed instructions plus 3 illegal and 1 overflow
  localparam int NUM_INSTR = 16;

  logic        clock = 1'b0;
  logic        reset;
  logic        overflow;
  opcode_t     opcode;
  funct_t      funct;
  logic        ir_write, reg_write, write_mem, epc_write, pc_write, pc_write_cond;
  alu_src_t    alu_srca, alu_srcb;
  alu_op_t     alu_op;
  iord_t       iord;
  pc_src_t     pc_src;
  reg_dst_t    reg_dst;
  mem_to_reg_t mem_to_reg;
  branch_t     branch_type;

  logic [31:0] lfsr = 32'hdd34_6e59;
  int          offset;
  int          issued = 0;
  int          order [12];

  `include "tb_checks.svh"

  mips_control uut (.*);

  always #(CLK_PERIOD / 2) clock = ~clock;

  // Galois LFSR stepped once per bit taken
  function automatic logic [5:0] lfsr_bits(input int n);
    logic [5:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[4:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return bits;
  endfunction

  function automatic logic is_kept(input opcode_t op);
    return op inside {OPCODE_R, OPCODE_J, OPCODE_JAL, OPCODE_BEQ, OPCODE_BNE, OPCODE_ADDI,
                      OPCODE_ADDIU, OPCODE_LW, OPCODE_SW};
  endfunction

  task automatic advance_cycle();
    @(negedge clock);
    offset++;
  endtask

  task automatic check_sp_word();
    check_bit(reg_write, 1'b1, "reg_write in reset");
    check_reg_dst(reg_dst, DST_SP, "reg_dst in reset");
    check_mem_to_reg(mem_to_reg, WB_SP_INIT, "mem_to_reg in reset");
    check_bit(ir_write, 1'b0, "ir_write in reset");
    check_bit(write_mem, 1'b0, "write_mem in reset");
    check_bit(epc_write, 1'b0, "epc_write in reset");
    check_bit(pc_write, 1'b0, "pc_write in reset");
    check_bit(pc_write_cond, 1'b0, "pc_write_cond in reset");
  endtask

  // Called in the fetch cycle; returns in the execute cycle
  task automatic start_instr(input opcode_t op, input funct_t fn);
    check_bit(ir_write, 1'b1, "ir_write in fetch");
    check_bit(pc_write, 1'b1, "pc_write in fetch");
    check_pc_src(pc_src, PC_SRC_ALU, "pc_src in fetch");
    check_alu_src(alu_srcb, SRCB_FOUR, "alu_srcb in fetch");
    check_alu_op(alu_op, ALU_ADD, "alu_op in fetch");
    opcode = op;
    funct = fn;
    offset = 0;
    issued++;
    repeat (3) advance_cycle();
  endtask

  task automatic end_instr(input int expected);
    while (!ir_write && offset < 12) advance_cycle();
    if (!ir_write) begin
      other_errors++;
      $display("No ir_write pulse within 12 cycles of instruction %0d at time %0t",
               issued, $time);
    end else begin
      check_length(offset, expected, "cycles between ir_write pulses");
    end
  endtask

  task automatic test_alu(input funct_t fn, input alu_op_t op, input mem_to_reg_t wb);
    start_instr(OPCODE_R, fn);
    check_alu_src(alu_srca, SRCA_REG_A, "alu_srca in ALU execute");
    check_alu_src(alu_srcb, SRCB_REG_B, "alu_srcb in ALU execute");
    check_alu_op(alu_op, op, "alu_op in ALU execute");
    advance_cycle();
    check_bit(reg_write, 1'b1, "reg_write in ALU writeback");
    check_reg_dst(reg_dst, DST_RD, "reg_dst in ALU writeback");
    check_mem_to_reg(mem_to_reg, wb, "mem_to_reg in ALU writeback");
    end_instr(5);
  endtask

  task automatic test_imm(input opcode_t op);
    start_instr(op, 6'h00);
    check_alu_src(alu_srca, SRCA_REG_A, "alu_srca in immediate execute");
    check_alu_src(alu_srcb, SRCB_IMM, "alu_srcb in immediate execute");
    advance_cycle();
    check_bit(reg_write, 1'b1, "reg_write in immediate writeback");
    check_reg_dst(reg_dst, DST_RT, "reg_dst in immediate writeback");
    check_mem_to_reg(mem_to_reg, WB_ALUOUT, "mem_to_reg in immediate writeback");
    end_instr(5);
  endtask

  task automatic test_load();
    start_instr(OPCODE_LW, 6'h00);
    check_iord(iord, IORD_ALUOUT, "iord in lw address");
    check_bit(reg_write, 1'b0, "reg_write in lw address");
    advance_cycle();
    check_iord(iord, IORD_ALUOUT, "iord in lw wait");
    advance_cycle();
    check_bit(reg_write, 1'b1, "reg_write in lw writeback");
    check_reg_dst(reg_dst, DST_RT, "reg_dst in lw writeback");
    check_mem_to_reg(mem_to_reg, WB_MEM, "mem_to_reg in lw writeback");
    end_instr(6);
  endtask

  task automatic test_store();
    start_instr(OPCODE_SW, 6'h00);
    check_bit(write_mem, 1'b1, "write_mem in sw");
    check_iord(iord, IORD_ALUOUT, "iord in sw");
    check_bit(reg_write, 1'b0, "reg_write in sw");
    advance_cycle();
    check_bit(reg_write, 1'b0, "reg_write in sw wait");
    end_instr(5);
  endtask

  task automatic test_branch(input opcode_t op, input branch_t br);
    start_instr(op, 6'h00);
    check_bit(pc_write_cond, 1'b1, "pc_write_cond in branch");
    check_bit(pc_write, 1'b0, "pc_write in branch");
    check_branch(branch_type, br, "branch_type in branch");
    check_pc_src(pc_src, PC_SRC_ALUOUT, "pc_src in branch");
    end_instr(4);
  endtask

  task automatic test_jump(input opcode_t op, input logic link);
    start_instr(op, 6'h00);
    check_bit(pc_write, 1'b1, "pc_write in jump");
    check_pc_src(pc_src, PC_SRC_JUMP, "pc_src in jump");
    check_bit(reg_write, link, "reg_write in jump");
    if (link) begin
      check_reg_dst(reg_dst, DST_RA, "reg_dst in jal");
      check_mem_to_reg(mem_to_reg, WB_PC, "mem_to_reg in jal");
    end
    end_instr(4);
  endtask

  // EPC takes PC minus 4
  task automatic check_exc_entry();
    check_bit(epc_write, 1'b1, "epc_write in exception entry");
    check_alu_src(alu_srca, SRCA_PC, "alu_srca in exception entry");
    check_alu_src(alu_srcb, SRCB_FOUR, "alu_srcb in exception entry");
    check_alu_op(alu_op, ALU_SUB, "alu_op in exception entry");
  endtask

  task automatic test_illegal();
    opcode_t op;
    do op = lfsr_bits(6); while (is_kept(op));
    start_instr(op, lfsr_bits(6));
    check_exc_entry();
    advance_cycle();
    check_iord(iord, IORD_INEX_VEC, "iord in illegal vector");
    repeat (2) advance_cycle();
    check_bit(pc_write, 1'b1, "pc_write in exception end");
    check_pc_src(pc_src, PC_SRC_EXC_VEC, "pc_src in exception end");
    end_instr(7);
  endtask

  task automatic test_overflow();
    start_instr(OPCODE_R, FUNCT_ADD);
    check_alu_op(alu_op, ALU_ADD, "alu_op in add before overflow");
    overflow = 1'b1;
    advance_cycle();
    overflow = 1'b0;
    check_exc_entry();
    // Writeback of the add would have fallen in this cycle
    check_bit(reg_write, 1'b0, "reg_write in overflow entry");
    advance_cycle();
    check_iord(iord, IORD_OVF_VEC, "iord in overflow vector");
    check_bit(reg_write, 1'b0, "reg_write after overflow");
    repeat (2) advance_cycle();
    check_bit(pc_write, 1'b1, "pc_write in exception end");
    check_pc_src(pc_src, PC_SRC_EXC_VEC, "pc_src in exception end");
    check_bit(reg_write, 1'b0, "reg_write in exception end");
    end_instr(8);
  endtask

  task automatic run_directed(input int id);
    case (id)
      0: test_alu(FUNCT_ADD, ALU_ADD, WB_ALUOUT);
      1: test_alu(FUNCT_AND, ALU_AND, WB_ALUOUT);
      2: test_alu(FUNCT_SUB, ALU_SUB, WB_ALUOUT);
      3: test_alu(FUNCT_SLT, ALU_SLT, WB_LT);
      4: test_imm(OPCODE_ADDI);
      5: test_imm(OPCODE_ADDIU);
      6: test_load();
      7: test_store();
      8: test_branch(OPCODE_BEQ, BR_EQ);
      9: test_branch(OPCODE_BNE, BR_NE);
      10: test_jump(OPCODE_J, 1'b0);
      default: test_jump(OPCODE_JAL, 1'b1);
    endcase
  endtask

  initial begin
    #(CLK_PERIOD * (12 * NUM_INSTR + 50));
    $display("Watchdog expired before the tests completed");
    $display("Test failures found");
    $finish;
  end

  initial begin
    int j;
    int tmp;
    reset = 1'b1;
    overflow = 1'b0;
    opcode = OPCODE_R;
    funct = FUNCT_ADD;
    repeat (2) begin
      @(negedge clock);
      check_sp_word();
    end
    reset = 1'b0;
    @(negedge clock);
    for (int i = 0; i < 12; i++) order[i] = i;
    for (int i = 11; i > 0; i--) begin
      j = int'(lfsr_bits(4)) % (i + 1);
      tmp = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    foreach (order[i]) run_directed(order[i]);
    repeat (2) test_illegal();
    test_overflow();
    // Illegal after overflow so the cause latch must clear
    test_illegal();
    $display("Errors: %0d value mismatches, %0d other failures over %0d instructions",
             value_errors, other_errors, issued);
    if (value_errors + other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* mips_control.f */
+incdir+bench
hw/mips_ctrl_pkg.sv
hw/ctrl_word_if.sv
hw/instr_decoder.sv
hw/ctrl_sequencer.sv
hw/ctrl_word_gen.sv
hw/mips_control.sv
bench/tb_mips_control.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator
set -u
cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_mips_control \
  -f mips_control.f --Mdir "$build_dir" -o sim_mips_control
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/sim_mips_control" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q 'All tests passed!' "$log_file"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
